/* design/quiz_macros.svh */
`ifndef QUIZ_MACROS_SVH
`define QUIZ_MACROS_SVH

// questions per game
`define QUIZ_NUM_Q 4
// wrong answers allowed
`define QUIZ_LIVES 2
// answer digits run 1..9
`define QUIZ_DIGIT_MAX 9
// cycles in QUESTION before input opens
`define QUIZ_SHOW_CYCLES 8

`endif

/* design/quiz_pkg.sv */
`default_nettype none

package quiz_pkg;

  // game states with fixed codes
  typedef enum logic [3:0] {
    ST_IDLE     = 4'd0,
    ST_READY    = 4'd2,
    ST_QUESTION = 4'd3,
    ST_INPUT    = 4'd4,
    // never entered
    ST_DRAW     = 4'd6,
    ST_WRONG    = 4'd7,
    ST_GOOD     = 4'd8,
    // never entered
    ST_OUCH     = 4'd9,
    ST_WIN      = 4'd10,
    ST_LOSE     = 4'd11
  } game_state_t;

  // one decimal digit where 0 means not entered
  typedef logic [3:0] digit_t;

  // any code above 9 decodes to a dark digit
  localparam digit_t DIGIT_BLANK = 4'hF;

  // difficulty then two question digits
  typedef struct packed {
    digit_t level;
    digit_t q_hi;
    digit_t q_lo;
  } question_t;

  // question on top of expected answer digits 2..0
  typedef struct packed {
    question_t      question;
    digit_t [2:0]   answer;
  } qset_t;

endpackage

`default_nettype wire

/* design/question_rom.sv */
`timescale 1ns/1ps
`default_nettype none
`include "quiz_macros.svh"

module question_rom
  import quiz_pkg::*;
(
  input  wire logic [$clog2(`QUIZ_NUM_Q)-1:0] q_index,
  output qset_t                               qset
);

  // layout: level, q_hi, q_lo, ans2, ans1, ans0
  always_comb begin
    case (q_index)
      0:       qset = 24'h112_135;
      1:       qset = 24'h147_219;
      2:       qset = 24'h256_384;
      3:       qset = 24'h389_767;
      // outside the table reads as empty
      default: qset = '0;
    endcase
  end

  // index must stay inside the table
  always_comb begin
    assert #0 (q_index < `QUIZ_NUM_Q)
      else $error("question_rom: index %0d out of range", q_index);
  end

endmodule

`default_nettype wire

/* design/answer_entry.sv */
`timescale 1ns/1ps
`default_nettype none
`include "quiz_macros.svh"

module answer_entry
  import quiz_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        rst_n,
  input  wire game_state_t state,
  input  wire qset_t       qset,
  input  wire logic [2:0]  sel,
  input  wire logic        dec,
  input  wire logic        clr,
  output logic             que_ok,
  output logic             led,
  output digit_t           ans_digit0,
  output digit_t           ans_digit1,
  output digit_t           ans_digit2,
  output digit_t           q_digit0,
  output digit_t           q_digit1,
  output digit_t           q_digit2,
  output digit_t [2:0]     answer,
  output logic             answer_valid,
  output digit_t [2:0]     expected
);

  // captured question and its answer
  question_t    q_r;
  digit_t [2:0] exp_r;
  // live answer digits
  digit_t [2:0] cnt;
  logic         keep_q;

  // 9 wraps back to 1 and empty 0 steps to 1
  function automatic digit_t step_digit(input digit_t d);
    if (d >= digit_t'(`QUIZ_DIGIT_MAX))
      return digit_t'(1);
    return d + digit_t'(1);
  endfunction

  // hold the question while a round is open
  assign keep_q = (state == ST_READY && qset.question != '0) ||
                  state inside {ST_QUESTION, ST_INPUT, ST_WRONG};

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      q_r   <= '0;
      exp_r <= '0;
    end else if (keep_q) begin
      q_r   <= qset.question;
      exp_r <= qset.answer;
    end else begin
      q_r   <= '0;
      exp_r <= '0;
    end
  end

  assign expected = exp_r;

  // question present flag with led one cycle behind
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      que_ok <= 1'b0;
      led    <= 1'b0;
    end else begin
      que_ok <= (q_r != '0);
      led    <= que_ok;
    end
  end

  // digit counters take one sel bit per cycle with bit 0 first
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (state == ST_INPUT) begin
      if (sel[0])
        cnt[0] <= step_digit(cnt[0]);
      else if (sel[1])
        cnt[1] <= step_digit(cnt[1]);
      else if (sel[2])
        cnt[2] <= step_digit(cnt[2]);
      else if (clr)
        cnt <= '0;
    end else if (state inside {ST_GOOD, ST_WIN, ST_LOSE}) begin
      // round over so the next entry starts empty
      cnt <= '0;
    end
  end

  // display registers
  // answer side shows only in INPUT and question side only in QUESTION
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ans_digit0 <= DIGIT_BLANK;
      ans_digit1 <= DIGIT_BLANK;
      ans_digit2 <= DIGIT_BLANK;
      q_digit0   <= '0;
      q_digit1   <= '0;
      q_digit2   <= '0;
    end else begin
      ans_digit0 <= (state == ST_INPUT) ? cnt[0] : DIGIT_BLANK;
      ans_digit1 <= (state == ST_INPUT) ? cnt[1] : DIGIT_BLANK;
      ans_digit2 <= (state == ST_INPUT) ? cnt[2] : DIGIT_BLANK;
      q_digit0   <= (state == ST_QUESTION) ? q_r.q_lo  : digit_t'(0);
      q_digit1   <= (state == ST_QUESTION) ? q_r.q_hi  : digit_t'(0);
      q_digit2   <= (state == ST_QUESTION) ? q_r.level : digit_t'(0);
    end
  end

  // submit on dec with a single valid pulse
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      answer       <= '0;
      answer_valid <= 1'b0;
    end else begin
      answer_valid <= (state == ST_INPUT) && dec;
      if (state == ST_INPUT && dec)
        answer <= cnt;
    end
  end

  // counters never leave 0..9
  assert property (@(posedge CLK) disable iff (!rst_n)
    cnt[0] <= `QUIZ_DIGIT_MAX && cnt[1] <= `QUIZ_DIGIT_MAX &&
    cnt[2] <= `QUIZ_DIGIT_MAX);

  // game still in INPUT while the submit goes out
  assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(answer_valid) |-> state == ST_INPUT);

endmodule

`default_nettype wire

/* design/answer_judge.sv */
`timescale 1ns/1ps
`default_nettype none

module answer_judge
  import quiz_pkg::*;
(
  input  wire logic         CLK,
  input  wire logic         rst_n,
  input  wire digit_t [2:0] answer,
  input  wire digit_t [2:0] expected,
  input  wire logic         answer_valid,
  output logic              correct,
  output logic              wrong
);

  logic match;

  // every digit equal and entered since empty never matches
  assign match = (answer == expected) &&
                 answer[0] != '0 && answer[1] != '0 && answer[2] != '0;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      correct <= 1'b0;
      wrong   <= 1'b0;
    end else begin
      correct <= answer_valid && match;
      wrong   <= answer_valid && !match;
    end
  end

  // never both verdicts at once
  assert property (@(posedge CLK) disable iff (!rst_n)
    (correct || wrong) |-> !(correct && wrong));

endmodule

`default_nettype wire

/* design/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "quiz_macros.svh"

module game_fsm
  import quiz_pkg::*;
(
  input  wire logic                            CLK,
  input  wire logic                            rst_n,
  input  wire logic                            start,
  input  wire logic                            que_ok,
  input  wire logic                            correct,
  input  wire logic                            wrong,
  output game_state_t                          state,
  output logic [$clog2(`QUIZ_NUM_Q)-1:0]       q_index,
  output logic [1:0]                           lives,
  output logic [2:0]                           score
);

  localparam int IDX_W  = $clog2(`QUIZ_NUM_Q);
  localparam int SHOW_W = $clog2(`QUIZ_SHOW_CYCLES);

  // cycles spent showing the question
  logic [SHOW_W-1:0] show_cnt;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      q_index  <= '0;
      lives    <= 2'(`QUIZ_LIVES);
      score    <= '0;
      show_cnt <= '0;
    end else begin
      // counter only runs in QUESTION
      show_cnt <= '0;
      case (state)
        ST_IDLE, ST_WIN, ST_LOSE: begin
          // fresh game
          if (start) begin
            state   <= ST_READY;
            q_index <= '0;
            lives   <= 2'(`QUIZ_LIVES);
            score   <= '0;
          end
        end
        ST_READY: begin
          if (que_ok)
            state <= ST_QUESTION;
        end
        ST_QUESTION: begin
          if (show_cnt == SHOW_W'(`QUIZ_SHOW_CYCLES - 1))
            state <= ST_INPUT;
          else
            show_cnt <= show_cnt + 1'b1;
        end
        ST_INPUT: begin
          if (correct) begin
            state <= ST_GOOD;
            score <= score + 1'b1;
          end else if (wrong) begin
            lives <= lives - 1'b1;
            // last life gone
            state <= (lives == 2'd1) ? ST_LOSE : ST_WRONG;
          end
        end
        ST_WRONG:
          state <= ST_INPUT;
        ST_GOOD: begin
          if (q_index == IDX_W'(`QUIZ_NUM_Q - 1)) begin
            state <= ST_WIN;
          end else begin
            state   <= ST_READY;
            q_index <= q_index + 1'b1;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // judge only speaks while the player is answering
  assert property (@(posedge CLK) disable iff (!rst_n)
    (correct || wrong) |-> state == ST_INPUT);

endmodule

`default_nettype wire

/* design/seg7_display.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_display
  import quiz_pkg::*;
(
  input  wire digit_t ans_digit0,
  input  wire digit_t ans_digit1,
  input  wire digit_t ans_digit2,
  input  wire digit_t q_digit0,
  input  wire digit_t q_digit1,
  input  wire digit_t q_digit2,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  logic q_dark;

  // segments gfedcba, active high
  function automatic logic [6:0] seg_dec(input digit_t d);
    case (d)
      4'd0:    return 7'h3F;
      4'd1:    return 7'h06;
      4'd2:    return 7'h5B;
      4'd3:    return 7'h4F;
      4'd4:    return 7'h66;
      4'd5:    return 7'h6D;
      4'd6:    return 7'h7D;
      4'd7:    return 7'h07;
      4'd8:    return 7'h7F;
      4'd9:    return 7'h6F;
      default: return 7'h00;
    endcase
  endfunction

  // empty answer digit shows a dash
  function automatic logic [6:0] ans_dec(input digit_t d);
    return (d == '0) ? 7'h40 : seg_dec(d);
  endfunction

  // all-zero question means nothing to show
  assign q_dark = (q_digit0 == '0) && (q_digit1 == '0) && (q_digit2 == '0);

  assign hex0 = ans_dec(ans_digit0);
  assign hex1 = ans_dec(ans_digit1);
  assign hex2 = ans_dec(ans_digit2);
  assign hex3 = q_dark ? 7'h00 : seg_dec(q_digit0);
  assign hex4 = q_dark ? 7'h00 : seg_dec(q_digit1);
  assign hex5 = q_dark ? 7'h00 : seg_dec(q_digit2);

endmodule

`default_nettype wire

/* design/quiz_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "quiz_macros.svh"

module quiz_top
  import quiz_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       rst_n,
  input  wire logic       start,
  input  wire logic [2:0] sel,
  input  wire logic       dec,
  input  wire logic       clr,
  output logic [6:0]      hex0,
  output logic [6:0]      hex1,
  output logic [6:0]      hex2,
  output logic [6:0]      hex3,
  output logic [6:0]      hex4,
  output logic [6:0]      hex5,
  output logic            led,
  output game_state_t     state,
  output logic [1:0]      lives,
  output logic [2:0]      score
);

  // rom to entry
  logic [$clog2(`QUIZ_NUM_Q)-1:0] q_index;
  qset_t                          qset;
  logic                           que_ok;
  // entry to display
  digit_t                         ans_digit0, ans_digit1, ans_digit2;
  digit_t                         q_digit0, q_digit1, q_digit2;
  // entry to judge, judge to fsm
  digit_t [2:0]                   answer;
  digit_t [2:0]                   expected;
  logic                           answer_valid;
  logic                           correct, wrong;

  question_rom u_rom (
    .q_index (q_index),
    .qset    (qset)
  );

  answer_entry u_entry (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .state        (state),
    .qset         (qset),
    .sel          (sel),
    .dec          (dec),
    .clr          (clr),
    .que_ok       (que_ok),
    .led          (led),
    .ans_digit0   (ans_digit0),
    .ans_digit1   (ans_digit1),
    .ans_digit2   (ans_digit2),
    .q_digit0     (q_digit0),
    .q_digit1     (q_digit1),
    .q_digit2     (q_digit2),
    .answer       (answer),
    .answer_valid (answer_valid),
    .expected     (expected)
  );

  answer_judge u_judge (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .answer       (answer),
    .expected     (expected),
    .answer_valid (answer_valid),
    .correct      (correct),
    .wrong        (wrong)
  );

  game_fsm u_fsm (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .start   (start),
    .que_ok  (que_ok),
    .correct (correct),
    .wrong   (wrong),
    .state   (state),
    .q_index (q_index),
    .lives   (lives),
    .score   (score)
  );

  seg7_display u_disp (
    .ans_digit0 (ans_digit0),
    .ans_digit1 (ans_digit1),
    .ans_digit2 (ans_digit2),
    .q_digit0   (q_digit0),
    .q_digit1   (q_digit1),
    .q_digit2   (q_digit2),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5)
  );

endmodule

`default_nettype wire

/* tests/quiz_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module quiz_checker
  import quiz_pkg::*;
(
  input wire logic [6:0]  hex0,
  input wire logic [6:0]  hex1,
  input wire logic [6:0]  hex2,
  input wire logic [6:0]  hex3,
  input wire logic [6:0]  hex4,
  input wire logic [6:0]  hex5,
  input wire logic        led,
  input wire game_state_t state,
  input wire logic [1:0]  lives,
  input wire logic [2:0]  score
);

  int pass_count = 0;
  int fail_count = 0;
  // lives and score seen at the previous check
  logic [1:0] last_lives = 2'd0;
  logic [2:0] last_score = 3'd0;

  // segment pattern back to a digit code
  // A is a dash, F is dark, E is anything else
  function automatic logic [3:0] seg_code(input logic [6:0] s);
    case (s)
      7'h3F:   return 4'd0;
      7'h06:   return 4'd1;
      7'h5B:   return 4'd2;
      7'h4F:   return 4'd3;
      7'h66:   return 4'd4;
      7'h6D:   return 4'd5;
      7'h7D:   return 4'd6;
      7'h07:   return 4'd7;
      7'h7F:   return 4'd8;
      7'h6F:   return 4'd9;
      7'h40:   return 4'hA;
      7'h00:   return 4'hF;
      default: return 4'hE;
    endcase
  endfunction

  // digits printed hex5 down to hex0
  function automatic string fields(input logic [33:0] v);
    return $sformatf("state=%0d lives=%0d score=%0d led=%b digits=%h",
                     v[33:30], v[29:28], v[27:25], v[24], v[23:0]);
  endfunction

  task automatic check_step(input string name, input logic submitted,
                            input logic [33:0] exp);
    logic [33:0] act;
    act = {state, lives, score, led, seg_code(hex5), seg_code(hex4), seg_code(hex3),
           seg_code(hex2), seg_code(hex1), seg_code(hex0)};
    // still answering with nothing counted
    if (submitted && state == ST_INPUT && lives == last_lives && score == last_score) begin
      fail_count++;
      $display("FAIL %s: answer was submitted but the game saw no verdict", name);
    end else if (act !== exp) begin
      fail_count++;
      $display("ERR %s expected %s actual %s", name, fields(exp), fields(act));
    end else begin
      pass_count++;
      $display("ok  %s", name);
    end
    last_lives = lives;
    last_score = score;
  endtask

endmodule

`default_nettype wire

/* tests/quiz_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "quiz_macros.svh"

module quiz_tb
  import quiz_pkg::*;
();

  // drive word is {start, sel[2:0], dec, clr}
  localparam logic [5:0]  D_NONE  = 6'b000000;
  localparam logic [5:0]  D_START = 6'b100000;
  localparam logic [5:0]  D_DEC   = 6'b000010;
  localparam logic [5:0]  D_CLR   = 6'b000001;
  // expected digit codes, dash and dark
  localparam logic [3:0]  DASH = 4'hA;
  localparam logic [11:0] DARK = 12'hFFF;
  // enough cycles to cover the question display
  localparam int SHOW_WAIT = `QUIZ_SHOW_CYCLES - 2;

  logic        CLK = 1'b0;
  logic        rst_n;
  logic        start;
  logic [2:0]  sel;
  logic        dec;
  logic        clr;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;
  logic        led;
  game_state_t state;
  logic [1:0]  lives;
  logic [2:0]  score;

  // stimulus table, one entry per step
  string       t_name[$];
  logic [5:0]  t_drv[$];
  int          t_wait[$];
  logic [33:0] t_exp[$];

  // what the game should hold right now
  logic [1:0]  m_lives;
  logic [2:0]  m_score;
  logic [3:0]  m_dig[3];

  int cycles = 0;
  int limit = 1000000;

  always #20 CLK = ~CLK;

  quiz_top DUT (
    .CLK   (CLK),
    .rst_n (rst_n),
    .start (start),
    .sel   (sel),
    .dec   (dec),
    .clr   (clr),
    .hex0  (hex0),
    .hex1  (hex1),
    .hex2  (hex2),
    .hex3  (hex3),
    .hex4  (hex4),
    .hex5  (hex5),
    .led   (led),
    .state (state),
    .lives (lives),
    .score (score)
  );

  quiz_checker chk (
    .hex0  (hex0),
    .hex1  (hex1),
    .hex2  (hex2),
    .hex3  (hex3),
    .hex4  (hex4),
    .hex5  (hex5),
    .led   (led),
    .state (state),
    .lives (lives),
    .score (score)
  );

  // run limit
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // level, q_hi, q_lo, then answer digits 2..0
  function automatic logic [23:0] qset_of(input int n);
    case (n)
      0:       return 24'h112135;
      1:       return 24'h147219;
      2:       return 24'h256384;
      default: return 24'h389767;
    endcase
  endfunction

  // 0 steps to 1, 9 wraps to 1
  function automatic logic [3:0] next_digit(input logic [3:0] d);
    return (d == `QUIZ_DIGIT_MAX) ? 4'd1 : d + 4'd1;
  endfunction

  // answer side as hex2..hex0 should show it
  function automatic logic [11:0] entry_shown();
    logic [11:0] v;
    for (int i = 0; i < 3; i++)
      v[i*4 +: 4] = (m_dig[i] == 4'd0) ? DASH : m_dig[i];
    return v;
  endfunction

  task automatic add_step(input string name, input logic [5:0] drv, input int w,
                          input game_state_t st, input logic led_on,
                          input logic [11:0] q_side, input logic [11:0] a_side);
    t_name.push_back(name);
    t_drv.push_back(drv);
    t_wait.push_back(w);
    t_exp.push_back({st, m_lives, m_score, led_on, q_side, a_side});
  endtask

  // one sel strobe on digit idx
  task automatic press(input string name, input int idx);
    m_dig[idx] = next_digit(m_dig[idx]);
    add_step(name, 6'b000100 << idx, 1, ST_INPUT, 1'b1, DARK, entry_shown());
  endtask

  task automatic set_digit(input string name, input int idx, input logic [3:0] target);
    while (m_dig[idx] != target)
      press(name, idx);
  endtask

  task automatic enter_answer(input string name, input logic [11:0] ans);
    for (int i = 0; i < 3; i++)
      set_digit(name, i, ans[i*4 +: 4]);
  endtask

  // enter the right answer, submit, expect the next question or WIN
  task automatic play_correct(input int n);
    logic [23:0] qs;
    logic [23:0] nx;
    qs = qset_of(n);
    nx = qset_of(n + 1);
    enter_answer($sformatf("enter_q%0d", n), qs[11:0]);
    m_score = m_score + 3'd1;
    foreach (m_dig[i])
      m_dig[i] = 4'd0;
    if (n == `QUIZ_NUM_Q - 1) begin
      add_step("correct_last", D_DEC, 6, ST_WIN, 1'b0, DARK, DARK);
    end else begin
      add_step($sformatf("correct_q%0d", n), D_DEC, 7, ST_QUESTION, 1'b1, nx[23:12], DARK);
      add_step($sformatf("show_q%0d", n + 1), D_NONE, SHOW_WAIT, ST_INPUT, 1'b1,
               DARK, {3{DASH}});
    end
  endtask

  task automatic build_table();
    logic [23:0] qs;
    logic [11:0] bad;
    m_lives = `QUIZ_LIVES;
    m_score = 3'd0;
    foreach (m_dig[i])
      m_dig[i] = 4'd0;
    add_step("after_reset", D_NONE, 1, ST_IDLE, 1'b0, DARK, DARK);
    // first game
    qs = qset_of(0);
    add_step("start", D_START, 5, ST_QUESTION, 1'b1, qs[23:12], DARK);
    add_step("show_q0", D_NONE, SHOW_WAIT, ST_INPUT, 1'b1, DARK, {3{DASH}});
    // ten strobes run digit 1 through 9 and back to 1
    for (int i = 0; i < 10; i++)
      press("wrap_d1", 1);
    // all sel bits, digit 0 only
    m_dig[0] = next_digit(m_dig[0]);
    add_step("sel_priority", 6'b011100, 1, ST_INPUT, 1'b1, DARK, entry_shown());
    // clr loses against sel
    m_dig[2] = next_digit(m_dig[2]);
    add_step("clr_under_sel", 6'b010001, 1, ST_INPUT, 1'b1, DARK, entry_shown());
    foreach (m_dig[i])
      m_dig[i] = 4'd0;
    add_step("clear", D_CLR, 1, ST_INPUT, 1'b1, DARK, {3{DASH}});
    play_correct(0);
    // random digits, each one off from the answer
    qs = qset_of(1);
    for (int i = 0; i < 3; i++) begin
      do
        bad[i*4 +: 4] = 4'(1 + ($urandom % 9));
      while (bad[i*4 +: 4] == qs[i*4 +: 4]);
    end
    enter_answer("enter_wrong", bad);
    m_lives = m_lives - 2'd1;
    add_step("wrong_random", D_DEC, 5, ST_INPUT, 1'b1, DARK, entry_shown());
    foreach (m_dig[i])
      m_dig[i] = 4'd0;
    add_step("clear_after_wrong", D_CLR, 1, ST_INPUT, 1'b1, DARK, {3{DASH}});
    // only digit 0 entered, last life goes
    set_digit("enter_partial", 0, 4'd4);
    m_lives = m_lives - 2'd1;
    m_dig[0] = 4'd0;
    add_step("wrong_partial", D_DEC, 6, ST_LOSE, 1'b0, DARK, DARK);
    // second game, straight through
    m_lives = `QUIZ_LIVES;
    m_score = 3'd0;
    qs = qset_of(0);
    add_step("restart", D_START, 5, ST_QUESTION, 1'b1, qs[23:12], DARK);
    add_step("show_q0_again", D_NONE, SHOW_WAIT, ST_INPUT, 1'b1, DARK, {3{DASH}});
    for (int n = 0; n < `QUIZ_NUM_Q; n++)
      play_correct(n);
  endtask

  // strobe for one cycle, wait, check mid-cycle
  task automatic apply_step(input int i);
    @(posedge CLK);
    #2;
    {start, sel, dec, clr} = t_drv[i];
    @(posedge CLK);
    #2;
    {start, sel, dec, clr} = D_NONE;
    repeat (t_wait[i]) @(posedge CLK);
    @(negedge CLK);
    chk.check_step(t_name[i], t_drv[i][1], t_exp[i]);
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    sel   = 3'b000;
    dec   = 1'b0;
    clr   = 1'b0;
    void'($urandom(75454));
    build_table();
    limit = t_name.size() * 40 + 8;
    repeat (8) @(posedge CLK);
    #2;
    rst_n = 1'b1;
    foreach (t_name[i])
      apply_step(i);
    $display("steps: %0d passed, %0d failed", chk.pass_count, chk.fail_count);
    if (chk.fail_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/quiz_pkg.sv
design/question_rom.sv
design/answer_entry.sv
design/answer_judge.sv
design/game_fsm.sv
design/seg7_display.sv
design/quiz_top.sv
tests/quiz_checker.sv
tests/quiz_tb.sv

/* Bender.yml */
package:
  name: quiz_game

export_include_dirs:
  - design

sources:
  - design/quiz_pkg.sv
  - design/question_rom.sv
  - design/answer_entry.sv
  - design/answer_judge.sv
  - design/game_fsm.sv
  - design/seg7_display.sv
  - design/quiz_top.sv
  - target: test
    files:
      - tests/quiz_checker.sv
      - tests/quiz_tb.sv
